/* files.f */
src/apu_pkg.sv
src/apu_dispatcher.sv
src/apu_unit.sv
src/apu_collector.sv
src/apu_cluster_wrapper.sv
sim/apu_cluster_assert.sv
sim/tb_apu_cluster.sv

/* Bender.yml */
package:
  name: apu_cluster

sources:
  # Synthesizable cluster, package first
  - src/apu_pkg.sv
  - src/apu_dispatcher.sv
  - src/apu_unit.sv
  - src/apu_collector.sv
  - src/apu_cluster_wrapper.sv
  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/apu_cluster_assert.sv
      - sim/tb_apu_cluster.sv

/* sim/tb_apu_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_apu_cluster;

  localparam int DATA_W     = apu_pkg::APU_DATA_W;
  localparam int FLAG_W     = apu_pkg::APU_NUSFLAGS;
  localparam int OP_W       = apu_pkg::APU_OP_W;
  localparam int NUM_UNITS  = apu_pkg::APU_NUM_UNITS;
  localparam int N_TABLE    = 10;
  localparam int N_RAND     = 40;
  localparam int RST_CYCLES = 8;
  // Table rows run in three phases, plus the random requests
  localparam int MAX_CYCLES = 20 * (3 * N_TABLE + N_RAND) + RST_CYCLES;
  // Longest wait for the outstanding results of one drain
  localparam int DRAIN_CYCLES = 8 + 8 * NUM_UNITS;

  logic                                      clk = 1'b0;
  logic                                      reset;
  logic                                      apu_req;
  logic                                      apu_gnt;
  logic [apu_pkg::APU_NARGS-1:0][DATA_W-1:0] apu_operands;
  logic [OP_W-1:0]                           apu_op;
  logic                                      apu_ready;
  logic                                      apu_valid;
  logic [DATA_W-1:0]                         apu_result;
  logic [FLAG_W-1:0]                         apu_flags;

  // Stimulus table, bit i of tab_rdy is ready in the i-th cycle after acceptance
  logic [DATA_W-1:0] tab_a   [N_TABLE];
  logic [DATA_W-1:0] tab_b   [N_TABLE];
  logic [DATA_W-1:0] tab_c   [N_TABLE];
  logic [OP_W-1:0]   tab_op  [N_TABLE];
  logic [7:0]        tab_rdy [N_TABLE];

  logic [DATA_W-1:0] exp_result_q [$];
  logic [FLAG_W-1:0] exp_flags_q [$];
  int                accept_cycle_q [$];
  int                cycles;
  int                value_errors;
  int                other_errors;
  logic              check_latency;
  logic              random_ready;
  integer            seed;

  apu_cluster_wrapper apu_cluster_wrapper_inst (
    .clk_i          (clk),
    .reset_i        (reset),
    .apu_req_i      (apu_req),
    .apu_gnt_o      (apu_gnt),
    .apu_operands_i (apu_operands),
    .apu_op_i       (apu_op),
    .apu_ready_i    (apu_ready),
    .apu_valid_o    (apu_valid),
    .apu_result_o   (apu_result),
    .apu_flags_o    (apu_flags)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: responses still missing after %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  // Reference model built from the opcode and flag rules
  function automatic logic [FLAG_W+DATA_W-1:0] predict(input logic [DATA_W-1:0] a,
      input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] c, input logic [OP_W-1:0] op);
    logic [2*DATA_W-1:0] wa;
    logic [2*DATA_W-1:0] wb;
    logic [2*DATA_W-1:0] prod;
    logic [DATA_W-1:0]   res;
    logic                carry;
    logic [FLAG_W-1:0]   flags;
    wa   = a;
    wb   = b;
    prod = wa * wb;
    case (op)
      apu_pkg::APU_OP_ADD: {carry, res} = {1'b0, a} + {1'b0, b};
      apu_pkg::APU_OP_SUB: begin
        res   = a - b;
        carry = (a < b);
      end
      apu_pkg::APU_OP_MUL: begin
        res   = prod[DATA_W-1:0];
        carry = |prod[2*DATA_W-1:DATA_W];
      end
      default: begin
        prod  = prod + c;
        res   = prod[DATA_W-1:0];
        carry = |prod[2*DATA_W-1:DATA_W];
      end
    endcase
    flags = '0;
    flags[apu_pkg::APU_FLAG_ZERO]  = (res == '0);
    flags[apu_pkg::APU_FLAG_CARRY] = carry;
    return {flags, res};
  endfunction

  task automatic check_result(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED apu_result_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_flags(input logic [FLAG_W-1:0] got, input logic [FLAG_W-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED apu_flags_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic set_entry(input int i, input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
      input logic [DATA_W-1:0] c, input logic [OP_W-1:0] op, input logic [7:0] rdy);
    tab_a[i]   = a;
    tab_b[i]   = b;
    tab_c[i]   = c;
    tab_op[i]  = op;
    tab_rdy[i] = rdy;
  endtask

  // Holds the request until it is granted, returns 1 ns after the accepting edge
  task automatic issue(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
      input logic [DATA_W-1:0] c, input logic [OP_W-1:0] op);
    logic granted;
    apu_req         = 1'b1;
    apu_operands[0] = a;
    apu_operands[1] = b;
    apu_operands[2] = c;
    apu_op          = op;
    do begin
      @(negedge clk);
      granted = apu_gnt;
      @(posedge clk);
      #1;
    end while (!granted);
    apu_req = 1'b0;
  endtask

  task automatic drain(input logic [7:0] pat);
    int i;
    i = 0;
    while (exp_result_q.size() != 0 && i < DRAIN_CYCLES) begin
      apu_ready = (i < 8) ? pat[i] : 1'b1;
      @(posedge clk);
      #1;
      i++;
    end
    apu_ready = 1'b1;
    if (exp_result_q.size() != 0) begin
      other_errors++;
      $display("%0d expected responses never arrived", exp_result_q.size());
    end
  endtask

  // Outputs are sampled at the falling edge, away from input changes
  always @(negedge clk) begin : monitor
    logic [FLAG_W+DATA_W-1:0] pred;
    int                       lat;
    if (!reset && apu_valid) begin
      if (exp_result_q.size() == 0) begin
        other_errors++;
        $display("A response arrived with no request outstanding");
      end else begin
        check_result(apu_result, exp_result_q.pop_front());
        check_flags(apu_flags, exp_flags_q.pop_front());
        lat = cycles - accept_cycle_q.pop_front();
        if (check_latency && lat != apu_pkg::APU_LATENCY) begin
          other_errors++;
          $display("Response came %0d cycles after acceptance", lat);
        end
      end
    end
    if (!reset && apu_req && apu_gnt) begin
      pred = predict(apu_operands[0], apu_operands[1], apu_operands[2], apu_op);
      exp_result_q.push_back(pred[DATA_W-1:0]);
      exp_flags_q.push_back(pred[FLAG_W+DATA_W-1:DATA_W]);
      accept_cycle_q.push_back(cycles);
      if (exp_result_q.size() > NUM_UNITS) begin
        other_errors++;
        $display("More requests in flight than there are units");
      end
    end
  end

  always @(posedge clk) begin : ready_toggle
    logic [31:0] r;
    #1;
    if (random_ready) begin
      r         = $random(seed);
      apu_ready = r[0];
    end
  end

  initial begin : stimulus
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] rc;
    logic [31:0] rop;
    seed          = 32'h806e_bcdf;
    reset         = 1'b1;
    apu_req       = 1'b0;
    apu_operands  = '0;
    apu_op        = apu_pkg::APU_OP_ADD;
    apu_ready     = 1'b1;
    cycles        = 0;
    value_errors  = 0;
    other_errors  = 0;
    check_latency = 1'b0;
    random_ready  = 1'b0;
    set_entry(0, 32'h0000_0005, 32'h0000_0007, 32'h0, apu_pkg::APU_OP_ADD, 8'hFF);
    set_entry(1, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0, apu_pkg::APU_OP_ADD, 8'hFF);
    set_entry(2, 32'h0000_000A, 32'h0000_000A, 32'h0, apu_pkg::APU_OP_SUB, 8'hFF);
    set_entry(3, 32'h0000_0003, 32'h0000_0005, 32'h0, apu_pkg::APU_OP_SUB, 8'hF3);
    set_entry(4, 32'h0001_0000, 32'h0001_0000, 32'h0, apu_pkg::APU_OP_MUL, 8'hFF);
    set_entry(5, 32'h0000_1234, 32'h0000_5678, 32'h0, apu_pkg::APU_OP_MUL, 8'hAA);
    set_entry(6, 32'h0000_0002, 32'h0000_0003, 32'h4, apu_pkg::APU_OP_MAC, 8'hFF);
    set_entry(7, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h1, apu_pkg::APU_OP_MAC, 8'h00);
    set_entry(8, 32'h0000_0000, 32'hDEAD_BEEF, 32'h0, apu_pkg::APU_OP_MAC, 8'hFF);
    set_entry(9, 32'h8000_0000, 32'h8000_0000, 32'h0, apu_pkg::APU_OP_ADD, 8'h33);
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;

    // Isolated requests with their own ready pattern
    for (int i = 0; i < N_TABLE; i++) begin
      check_latency = (tab_rdy[i] == 8'hFF);
      issue(tab_a[i], tab_b[i], tab_c[i], tab_op[i]);
      drain(tab_rdy[i]);
    end

    // Back to back with ready high
    check_latency = 1'b1;
    for (int i = 0; i < N_TABLE; i++) begin
      issue(tab_a[i], tab_b[i], tab_c[i], tab_op[i]);
    end
    drain(8'hFF);
    check_latency = 1'b0;

    // Back-pressure fills every unit, then the grant has to stay low
    apu_ready = 1'b0;
    for (int i = 0; i < NUM_UNITS; i++) begin
      issue(tab_a[i], tab_b[i], tab_c[i], tab_op[i]);
    end
    if (exp_result_q.size() != NUM_UNITS) begin
      other_errors++;
      $display("Only %0d requests in flight with ready low", exp_result_q.size());
    end
    apu_req         = 1'b1;
    apu_operands[0] = tab_a[NUM_UNITS];
    apu_operands[1] = tab_b[NUM_UNITS];
    apu_operands[2] = tab_c[NUM_UNITS];
    apu_op          = tab_op[NUM_UNITS];
    repeat (6) begin
      @(negedge clk);
      if (apu_gnt) begin
        other_errors++;
        $display("Grant given while every unit holds a result");
      end
      @(posedge clk);
      #1;
    end
    apu_ready = 1'b1;
    issue(tab_a[NUM_UNITS], tab_b[NUM_UNITS], tab_c[NUM_UNITS], tab_op[NUM_UNITS]);
    drain(8'hFF);

    // Random requests against a randomly toggling ready
    random_ready = 1'b1;
    repeat (N_RAND) begin
      ra  = $random(seed);
      rb  = $random(seed);
      rc  = $random(seed);
      rop = $random(seed);
      issue(ra, rb, rc, rop[OP_W-1:0]);
    end
    random_ready = 1'b0;
    drain(8'hFF);

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/apu_cluster_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_cluster_assert (
  input logic                                                    clk_i,
  input logic                                                    reset_i,
  input logic                                                    apu_req_i,
  input logic                                                    apu_gnt_o,
  input logic [apu_pkg::APU_NARGS-1:0][apu_pkg::APU_DATA_W-1:0]  apu_operands_i,
  input logic [apu_pkg::APU_OP_W-1:0]                            apu_op_i,
  input logic                                                    apu_ready_i,
  input logic                                                    apu_valid_o
);

  logic accepted_q;

  // Goes high at the first accepted request after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      accepted_q <= 1'b0;
    end else if (apu_req_i && apu_gnt_o) begin
      accepted_q <= 1'b1;
    end
  end

  valid_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    apu_valid_o |-> apu_ready_i)
    else $error("apu_valid_o fired while apu_ready_i was low");

  // A waiting request keeps its operands and opcode
  operands_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (apu_req_i && !apu_gnt_o) |=>
      (!apu_req_i || ($stable(apu_operands_i) && $stable(apu_op_i))))
    else $error("Request payload changed before the grant");

  no_early_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    !accepted_q |-> !apu_valid_o)
    else $error("apu_valid_o fired before any request was accepted");

endmodule

bind apu_cluster_wrapper apu_cluster_assert apu_cluster_assert_inst (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .apu_req_i      (apu_req_i),
  .apu_gnt_o      (apu_gnt_o),
  .apu_operands_i (apu_operands_i),
  .apu_op_i       (apu_op_i),
  .apu_ready_i    (apu_ready_i),
  .apu_valid_o    (apu_valid_o)
);

`default_nettype wire

/* src/apu_cluster_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_cluster_wrapper (
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,
  // Request channel
  input  logic                                                    apu_req_i,
  output logic                                                    apu_gnt_o,
  input  logic [apu_pkg::APU_NARGS-1:0][apu_pkg::APU_DATA_W-1:0]  apu_operands_i,
  input  logic [apu_pkg::APU_OP_W-1:0]                            apu_op_i,
  // Response channel
  input  logic                                                    apu_ready_i,
  output logic                                                    apu_valid_o,
  output logic [apu_pkg::APU_DATA_W-1:0]                          apu_result_o,
  output logic [apu_pkg::APU_NUSFLAGS-1:0]                        apu_flags_o
);

  logic [apu_pkg::APU_NUM_UNITS-1:0]                            unit_start;
  logic [apu_pkg::APU_NUM_UNITS-1:0]                            unit_busy;
  logic [apu_pkg::APU_NUM_UNITS-1:0]                            unit_done;
  logic [apu_pkg::APU_NUM_UNITS-1:0]                            unit_release;
  logic [apu_pkg::APU_NARGS-1:0][apu_pkg::APU_DATA_W-1:0]       unit_operands;
  logic [apu_pkg::APU_OP_W-1:0]                                 unit_op;
  logic [apu_pkg::APU_NUM_UNITS-1:0][apu_pkg::APU_DATA_W-1:0]   unit_result;
  logic [apu_pkg::APU_NUM_UNITS-1:0][apu_pkg::APU_NUSFLAGS-1:0] unit_flags;
  logic                                                         issue_valid;
  logic [apu_pkg::APU_UNIT_IDX_W-1:0]                           issue_unit;

  apu_dispatcher apu_dispatcher_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .apu_req_i       (apu_req_i),
    .apu_gnt_o       (apu_gnt_o),
    .apu_operands_i  (apu_operands_i),
    .apu_op_i        (apu_op_i),
    .unit_busy_i     (unit_busy),
    .unit_start_o    (unit_start),
    .unit_operands_o (unit_operands),
    .unit_op_o       (unit_op),
    .issue_valid_o   (issue_valid),
    .issue_unit_o    (issue_unit)
  );

  // Pool of identical units on the shared operand bus
  for (genvar g = 0; g < apu_pkg::APU_NUM_UNITS; g++) begin : gen_units
    apu_unit apu_unit_inst (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .start_i    (unit_start[g]),
      .operands_i (unit_operands),
      .op_i       (unit_op),
      .release_i  (unit_release[g]),
      .busy_o     (unit_busy[g]),
      .done_o     (unit_done[g]),
      .result_o   (unit_result[g]),
      .flags_o    (unit_flags[g])
    );
  end

  apu_collector apu_collector_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .issue_valid_i  (issue_valid),
    .issue_unit_i   (issue_unit),
    .unit_done_i    (unit_done),
    .unit_result_i  (unit_result),
    .unit_flags_i   (unit_flags),
    .unit_release_o (unit_release),
    .apu_ready_i    (apu_ready_i),
    .apu_valid_o    (apu_valid_o),
    .apu_result_o   (apu_result_o),
    .apu_flags_o    (apu_flags_o)
  );

endmodule

`default_nettype wire

/* src/apu_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_collector (
  input  logic                                                        clk_i,
  input  logic                                                        reset_i,
  // Issue order from the dispatcher
  input  logic                                                        issue_valid_i,
  input  logic [apu_pkg::APU_UNIT_IDX_W-1:0]                          issue_unit_i,
  // Unit pool
  input  logic [apu_pkg::APU_NUM_UNITS-1:0]                           unit_done_i,
  input  logic [apu_pkg::APU_NUM_UNITS-1:0][apu_pkg::APU_DATA_W-1:0]  unit_result_i,
  input  logic [apu_pkg::APU_NUM_UNITS-1:0][apu_pkg::APU_NUSFLAGS-1:0] unit_flags_i,
  output logic [apu_pkg::APU_NUM_UNITS-1:0]                           unit_release_o,
  // Response channel to the master
  input  logic                                                        apu_ready_i,
  output logic                                                        apu_valid_o,
  output logic [apu_pkg::APU_DATA_W-1:0]                              apu_result_o,
  output logic [apu_pkg::APU_NUSFLAGS-1:0]                            apu_flags_o
);

  localparam int unsigned NUM_UNITS = apu_pkg::APU_NUM_UNITS;
  localparam int unsigned IDX_W     = apu_pkg::APU_UNIT_IDX_W;

  // Order queue of unit indices, one entry per busy unit
  logic [IDX_W-1:0] order_q [NUM_UNITS];
  logic [IDX_W-1:0] wr_ptr_q;
  logic [IDX_W-1:0] rd_ptr_q;
  logic [IDX_W:0]   count_q;
  logic [IDX_W-1:0] head;
  logic             fire;

  assign head = order_q[rd_ptr_q];
  assign fire = (count_q != '0) && unit_done_i[head] && apu_ready_i;

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      order_q[wr_ptr_q] <= issue_unit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (issue_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == IDX_W'(NUM_UNITS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (fire) begin
        rd_ptr_q <= (rd_ptr_q == IDX_W'(NUM_UNITS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop in the same cycle leave the count unchanged
      if (issue_valid_i && !fire) begin
        count_q <= count_q + 1'b1;
      end else if (fire && !issue_valid_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Release the head unit together with the response strobe
  always_comb begin
    unit_release_o = '0;
    if (fire) begin
      unit_release_o[head] = 1'b1;
    end
  end

  assign apu_valid_o  = fire;
  assign apu_result_o = unit_result_i[head];
  assign apu_flags_o  = unit_flags_i[head];

endmodule

`default_nettype wire

/* src/apu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_unit (
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,
  input  logic                                                    start_i,
  input  logic [apu_pkg::APU_NARGS-1:0][apu_pkg::APU_DATA_W-1:0]  operands_i,
  input  logic [apu_pkg::APU_OP_W-1:0]                            op_i,
  input  logic                                                    release_i,
  output logic                                                    busy_o,
  output logic                                                    done_o,
  output logic [apu_pkg::APU_DATA_W-1:0]                          result_o,
  output logic [apu_pkg::APU_NUSFLAGS-1:0]                        flags_o
);

  localparam int unsigned DATA_W = apu_pkg::APU_DATA_W;
  localparam int unsigned CNT_W  = apu_pkg::APU_LAT_CNT_W;

  logic                                          busy_q;
  logic                                          done_q;
  logic [CNT_W-1:0]                              cnt_q;
  logic [apu_pkg::APU_NARGS-1:0][DATA_W-1:0]     opnd_q;
  logic [apu_pkg::APU_OP_W-1:0]                  op_q;
  logic [2*DATA_W-1:0]                           opa;
  logic [2*DATA_W-1:0]                           opb;
  logic [2*DATA_W-1:0]                           opc;
  logic [2*DATA_W-1:0]                           wide;
  logic [DATA_W-1:0]                             result_q;
  logic [apu_pkg::APU_NUSFLAGS-1:0]              flags_q;
  logic                                          finish;

  // Last countdown step, done rises at this edge
  assign finish = busy_q && !done_q && (cnt_q == CNT_W'(1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
      cnt_q  <= CNT_W'(apu_pkg::APU_LATENCY - 1);
    end else if (release_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else if (busy_q && !done_q) begin
      cnt_q <= cnt_q - 1'b1;
      if (finish) begin
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      opnd_q <= operands_i;
      op_q   <= op_i;
    end
  end

  // Zero-extended operands into a 64-bit datapath
  assign opa = {{DATA_W{1'b0}}, opnd_q[0]};
  assign opb = {{DATA_W{1'b0}}, opnd_q[1]};
  assign opc = {{DATA_W{1'b0}}, opnd_q[2]};

  always_comb begin
    case (op_q)
      apu_pkg::APU_OP_ADD: wide = opa + opb;
      apu_pkg::APU_OP_SUB: wide = opa - opb;
      apu_pkg::APU_OP_MUL: wide = opa * opb;
      default:             wide = opa * opb + opc;
    endcase
  end

  // Borrow on subtract wraps into the upper half, so one carry rule covers all ops
  always_ff @(posedge clk_i) begin
    if (finish) begin
      result_q                        <= wide[DATA_W-1:0];
      flags_q[apu_pkg::APU_FLAG_ZERO]  <= (wide[DATA_W-1:0] == '0);
      flags_q[apu_pkg::APU_FLAG_CARRY] <= |wide[2*DATA_W-1:DATA_W];
    end
  end

  assign busy_o   = busy_q;
  assign done_o   = done_q;
  assign result_o = result_q;
  assign flags_o  = flags_q;

endmodule

`default_nettype wire

/* src/apu_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_dispatcher (
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,
  // Request channel from the master
  input  logic                                                    apu_req_i,
  output logic                                                    apu_gnt_o,
  input  logic [apu_pkg::APU_NARGS-1:0][apu_pkg::APU_DATA_W-1:0]  apu_operands_i,
  input  logic [apu_pkg::APU_OP_W-1:0]                            apu_op_i,
  // Unit pool
  input  logic [apu_pkg::APU_NUM_UNITS-1:0]                       unit_busy_i,
  output logic [apu_pkg::APU_NUM_UNITS-1:0]                       unit_start_o,
  output logic [apu_pkg::APU_NARGS-1:0][apu_pkg::APU_DATA_W-1:0]  unit_operands_o,
  output logic [apu_pkg::APU_OP_W-1:0]                            unit_op_o,
  // Issue order towards the collector
  output logic                                                    issue_valid_o,
  output logic [apu_pkg::APU_UNIT_IDX_W-1:0]                      issue_unit_o
);

  localparam int unsigned NUM_UNITS = apu_pkg::APU_NUM_UNITS;
  localparam int unsigned IDX_W     = apu_pkg::APU_UNIT_IDX_W;

  logic [IDX_W-1:0] ptr_q;
  logic [IDX_W-1:0] sel;
  logic             found;
  logic             accept;

  // First idle unit at or after the round-robin pointer
  always_comb begin : find_free
    logic [IDX_W-1:0] cand;
    found = 1'b0;
    sel   = ptr_q;
    for (int i = 0; i < NUM_UNITS; i++) begin
      cand = IDX_W'((int'(ptr_q) + i) % NUM_UNITS);
      if (!found && !unit_busy_i[cand]) begin
        found = 1'b1;
        sel   = cand;
      end
    end
  end

  assign accept    = apu_req_i && found;
  assign apu_gnt_o = accept;

  // Start strobe goes to the selected unit in the accepting cycle
  always_comb begin
    unit_start_o = '0;
    if (accept) begin
      unit_start_o[sel] = 1'b1;
    end
  end

  // All units share one operand bus, only the started one captures it
  assign unit_operands_o = apu_operands_i;
  assign unit_op_o       = apu_op_i;

  assign issue_valid_o = accept;
  assign issue_unit_o  = sel;

  // Pointer moves one past the unit that was just started
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (accept) begin
      ptr_q <= (sel == IDX_W'(NUM_UNITS - 1)) ? '0 : sel + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/apu_pkg.sv */
`default_nettype none

package apu_pkg;

  // Operand and result width
  localparam int unsigned APU_DATA_W = 32;

  // Three operands per request so that multiply-accumulate has its addend
  localparam int unsigned APU_NARGS = 3;

  localparam int unsigned APU_OP_W = 2;

  // Response flags returned with every result
  localparam int unsigned APU_NUSFLAGS = 2;

  // Size of the unit pool and the width of an index into it
  localparam int unsigned APU_NUM_UNITS = 4;
  localparam int unsigned APU_UNIT_IDX_W = $clog2(APU_NUM_UNITS);

  // Cycles from start to done in one unit, at least 2
  localparam int unsigned APU_LATENCY = 3;

  // Width of the per-unit countdown
  localparam int unsigned APU_LAT_CNT_W = $clog2(APU_LATENCY);

  // Opcode encoding
  localparam logic [APU_OP_W-1:0] APU_OP_ADD = 2'd0;
  localparam logic [APU_OP_W-1:0] APU_OP_SUB = 2'd1;
  localparam logic [APU_OP_W-1:0] APU_OP_MUL = 2'd2;
  localparam logic [APU_OP_W-1:0] APU_OP_MAC = 2'd3;

  // Bit positions inside the response flags
  localparam int unsigned APU_FLAG_ZERO = 0;
  // Carry out for add, borrow for subtract, nonzero upper half for multiplies
  localparam int unsigned APU_FLAG_CARRY = 1;

endpackage

`default_nettype wire
